// ==== rtl/dacPkg.sv ====
package dacPkg;

    // cell counts of the segmented array
    localparam int NumBinaryCells = 6;                    // binary weighted LSB segment
    localparam int NumThermCells  = 15;                   // unary MSB segment
    localparam int NumCells       = NumBinaryCells + NumThermCells;

    localparam int CurrentWidth = 11;                     // enough for the 1023 LSB full scale
    localparam int CalSelWidth  = 5;                      // covers select values 0 to 31

    // current count in units of the LSB cell
    typedef logic [CurrentWidth-1:0] current_t;

    // one thermometer cell carries the whole binary range plus one
    localparam current_t ThermWeight = current_t'(1 << NumBinaryCells);

    typedef logic [NumBinaryCells-1:0] binCode_t;         // binary code word
    typedef logic [NumThermCells-1:0]  thermCode_t;       // thermometer code word
    typedef logic [CalSelWidth-1:0]    calSel_t;          // 0 means no cell under calibration

    // where a unit cell sends its current
    typedef enum logic [1:0] {
        steerOff,                                         // cell disabled, no current anywhere
        steerPos,                                         // current to iOut
        steerNeg,                                         // current to iOutB
        steerCal                                          // current to iCal only
    } steer_e;

    // registered contribution of a single cell
    typedef struct packed {
        current_t posCurrent;
        current_t negCurrent;
        current_t calCurrent;
    } cellOut_t;

    // per word status that travels beside the currents
    typedef struct packed {
        logic active;                                     // word was powered up
        logic fault;                                      // at least one illegal pair
    } frameInfo_t;

endpackage

// ==== rtl/dacCodeDecoder.sv ====
`timescale 1ns/1ps

module dacCodeDecoder (
    input  logic               clk,
    input  logic               reset,
    input  dacPkg::binCode_t   dataIn,
    input  dacPkg::binCode_t   dataInB,
    input  dacPkg::thermCode_t dataTherm,
    input  dacPkg::thermCode_t dataThermB,
    input  dacPkg::calSel_t    calSelect,
    input  logic               powerDownB,
    output dacPkg::steer_e     cellCmd [dacPkg::NumCells],
    output dacPkg::frameInfo_t frameInfo
);

    // input sampling stage
    dacPkg::binCode_t   binReg;
    dacPkg::binCode_t   binBReg;
    dacPkg::thermCode_t thermReg;
    dacPkg::thermCode_t thermBReg;
    dacPkg::calSel_t    calSelReg;
    logic               powerUpReg;

    // per cell view of the sampled word, binary cells first
    logic [dacPkg::NumCells-1:0] cellBit;
    logic [dacPkg::NumCells-1:0] cellBitB;
    logic [dacPkg::NumCells-1:0] pairBad;
    logic [dacPkg::NumCells-1:0] calHit;

    dacPkg::steer_e     nextCmd [dacPkg::NumCells];
    dacPkg::frameInfo_t nextFrame;

    always_ff @(posedge clk) begin
        if (reset) begin
            binReg     <= '0;
            binBReg    <= '0;
            thermReg   <= '0;
            thermBReg  <= '0;
            calSelReg  <= '0;
            powerUpReg <= 1'b0;                           // comes out of reset powered down
        end else begin
            binReg     <= dataIn;
            binBReg    <= dataInB;
            thermReg   <= dataTherm;
            thermBReg  <= dataThermB;
            calSelReg  <= calSelect;
            powerUpReg <= powerDownB;
        end
    end

    assign cellBit  = {thermReg, binReg};                 // cell k is binary bit k for k < 6
    assign cellBitB = {thermBReg, binBReg};
    assign pairBad  = ~(cellBit ^ cellBitB);              // true and complement must differ

    // select value s picks cell s-1, anything above NumCells matches nothing
    always_comb begin
        for (int i = 0; i < dacPkg::NumCells; i++) begin
            calHit[i] = (calSelReg == dacPkg::calSel_t'(i + 1));
        end
    end

    // steering priority: power-down, bad pair, calibration, then the data bit
    always_comb begin
        for (int i = 0; i < dacPkg::NumCells; i++) begin
            if (!powerUpReg) begin
                nextCmd[i] = dacPkg::steerOff;
            end else if (pairBad[i]) begin
                nextCmd[i] = dacPkg::steerOff;            // illegal pair delivers nothing
            end else if (calHit[i]) begin
                nextCmd[i] = dacPkg::steerCal;
            end else if (cellBit[i]) begin
                nextCmd[i] = dacPkg::steerPos;
            end else begin
                nextCmd[i] = dacPkg::steerNeg;
            end
        end
    end

    always_comb begin
        nextFrame.active = powerUpReg;
        nextFrame.fault  = powerUpReg & (|pairBad);       // no fault reported while powered down
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dacPkg::NumCells; i++) begin
                cellCmd[i] <= dacPkg::steerOff;
            end
            frameInfo <= '0;
        end else begin
            for (int i = 0; i < dacPkg::NumCells; i++) begin
                cellCmd[i] <= nextCmd[i];
            end
            frameInfo <= nextFrame;
        end
    end

endmodule

// ==== rtl/steeringCell.sv ====
`timescale 1ns/1ps

module steeringCell #(
    parameter dacPkg::current_t Weight = dacPkg::current_t'(1)  // current of this cell in LSB units
) (
    input  logic             clk,
    input  logic             reset,
    input  dacPkg::steer_e   cmd,
    output dacPkg::cellOut_t contribution
);

    dacPkg::cellOut_t nextOut;

    // the cell current lands on one rail only, the others stay at zero
    always_comb begin
        nextOut = '0;
        case (cmd)
            dacPkg::steerPos: begin
                nextOut.posCurrent = Weight;
            end
            dacPkg::steerNeg: begin
                nextOut.negCurrent = Weight;
            end
            dacPkg::steerCal: begin
                nextOut.calCurrent = Weight;              // isolated from both outputs
            end
            default: begin
                nextOut = '0;                             // steerOff, cell switched away
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            contribution <= '0;
        end else begin
            contribution <= nextOut;
        end
    end

endmodule

// ==== rtl/outputCombiner.sv ====
`timescale 1ns/1ps

module outputCombiner (
    input  logic               clk,
    input  logic               reset,
    input  dacPkg::cellOut_t   cellCurrents [dacPkg::NumCells],
    input  dacPkg::frameInfo_t frameInfo,
    output dacPkg::current_t   iOut,
    output dacPkg::current_t   iOutB,
    output dacPkg::current_t   iCal,
    output logic               outputActive,
    output logic               pairFault
);

    dacPkg::current_t   posSum;
    dacPkg::current_t   negSum;
    dacPkg::current_t   calSum;
    dacPkg::frameInfo_t frameDelay;                       // flags of the word now held in the cells

    // summing node of each rail, full scale fits in current_t
    always_comb begin
        posSum = '0;
        negSum = '0;
        calSum = '0;
        for (int i = 0; i < dacPkg::NumCells; i++) begin
            posSum = posSum + cellCurrents[i].posCurrent;
            negSum = negSum + cellCurrents[i].negCurrent;
            calSum = calSum + cellCurrents[i].calCurrent;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            iOut  <= '0;
            iOutB <= '0;
            iCal  <= '0;
        end else begin
            iOut  <= posSum;
            iOutB <= negSum;
            iCal  <= calSum;
        end
    end

    // flags wait one stage for the cells and one for the sums
    always_ff @(posedge clk) begin
        if (reset) begin
            frameDelay   <= '0;
            outputActive <= 1'b0;
            pairFault    <= 1'b0;
        end else begin
            frameDelay   <= frameInfo;
            outputActive <= frameDelay.active;
            pairFault    <= frameDelay.fault;
        end
    end

endmodule

// ==== rtl/currentSteeringDac.sv ====
`timescale 1ns/1ps

module currentSteeringDac (
    input  logic               clk,
    input  logic               reset,
    input  dacPkg::binCode_t   dataIn,
    input  dacPkg::binCode_t   dataInB,
    input  dacPkg::thermCode_t dataTherm,
    input  dacPkg::thermCode_t dataThermB,
    input  dacPkg::calSel_t    calSelect,
    input  logic               powerDownB,
    output dacPkg::current_t   iOut,
    output dacPkg::current_t   iOutB,
    output dacPkg::current_t   iCal,
    output logic               outputActive,
    output logic               pairFault
);

    dacPkg::steer_e     cellCmd      [dacPkg::NumCells];
    dacPkg::cellOut_t   cellCurrents [dacPkg::NumCells];
    dacPkg::frameInfo_t frameInfo;

    dacCodeDecoder uDecoder (
        .clk        (clk),
        .reset      (reset),
        .dataIn     (dataIn),
        .dataInB    (dataInB),
        .dataTherm  (dataTherm),
        .dataThermB (dataThermB),
        .calSelect  (calSelect),
        .powerDownB (powerDownB),
        .cellCmd    (cellCmd),
        .frameInfo  (frameInfo)
    );

    // binary cells weigh 2^k, every thermometer cell weighs ThermWeight
    for (genvar k = 0; k < dacPkg::NumCells; k++) begin : gCell
        steeringCell #(
            .Weight ((k < dacPkg::NumBinaryCells) ? dacPkg::current_t'(1 << k)
                                                  : dacPkg::ThermWeight)
        ) uCell (
            .clk          (clk),
            .reset        (reset),
            .cmd          (cellCmd[k]),
            .contribution (cellCurrents[k])
        );
    end

    outputCombiner uCombiner (
        .clk          (clk),
        .reset        (reset),
        .cellCurrents (cellCurrents),
        .frameInfo    (frameInfo),
        .iOut         (iOut),
        .iOutB        (iOutB),
        .iCal         (iCal),
        .outputActive (outputActive),
        .pairFault    (pairFault)
    );

endmodule

// ==== bench/dacTb_properties.sv ====
`timescale 1ns/1ps

module dacTb_properties (
    input logic             clk,
    input logic             reset,
    input dacPkg::current_t iOut,
    input dacPkg::current_t iOutB,
    input dacPkg::current_t iCal,
    input logic             outputActive,
    input logic             pairFault
);

    localparam int FullScale = 1023;                      // sum of all 21 cell weights

    int assertFails = 0;                                  // count of failed assertions

    // an inactive output carries no current on any rail
    property idleZero;
        @(posedge clk) disable iff (reset)
            !outputActive |-> (iOut == '0 && iOutB == '0 && iCal == '0);
    endproperty

    // a clean active word keeps every cell current somewhere
    property fullScaleSum;
        @(posedge clk) disable iff (reset)
            (outputActive && !pairFault) |->
                (int'(iOut) + int'(iOutB) + int'(iCal) == FullScale);
    endproperty

    idleZeroCheck: assert property (idleZero)
        else begin
            assertFails++;
            $error("current present while outputActive is low");
        end

    fullScaleCheck: assert property (fullScaleSum)
        else begin
            assertFails++;
            $error("iOut + iOutB + iCal differs from full scale on a clean word");
        end

endmodule

bind outputCombiner dacTb_properties uProps (
    .clk          (clk),
    .reset        (reset),
    .iOut         (iOut),
    .iOutB        (iOutB),
    .iCal         (iCal),
    .outputActive (outputActive),
    .pairFault    (pairFault)
);

// ==== bench/dacTb.sv ====
`timescale 1ns/1ps

module dacTb;

    localparam int TestCycles = 200;                      // rough length of all tests
    localparam int MaxCycles  = 3 * TestCycles;
    localparam int FullScale  = 1023;
    localparam int ThermW     = 64;
    localparam int PipeDepth  = 4;                        // drive to check distance in cycles

    typedef struct packed {
        logic             check;                          // 0 for filler words
        dacPkg::current_t pos;
        dacPkg::current_t neg;
        dacPkg::current_t cal;
        logic             active;
        logic             fault;
    } expect_t;

    logic               clk = 1'b0;
    logic               reset;
    dacPkg::binCode_t   dataIn;
    dacPkg::binCode_t   dataInB;
    dacPkg::thermCode_t dataTherm;
    dacPkg::thermCode_t dataThermB;
    dacPkg::calSel_t    calSelect;
    logic               powerDownB;
    dacPkg::current_t   iOut;
    dacPkg::current_t   iOutB;
    dacPkg::current_t   iCal;
    logic               outputActive;
    logic               pairFault;

    expect_t expQ [$];                                    // words in flight, oldest first
    int      seed       = 32'h70b93a70;
    int      cycleCount = 0;

    currentSteeringDac uut (
        .clk          (clk),
        .reset        (reset),
        .dataIn       (dataIn),
        .dataInB      (dataInB),
        .dataTherm    (dataTherm),
        .dataThermB   (dataThermB),
        .calSelect    (calSelect),
        .powerDownB   (powerDownB),
        .iOut         (iOut),
        .iOutB        (iOutB),
        .iCal         (iCal),
        .outputActive (outputActive),
        .pairFault    (pairFault)
    );

    always #2 clk = ~clk;

    // assertion results of the previous edge are visible here
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (uut.uCombiner.uProps.assertFails != 0) begin
            $display("A bound assertion on the outputs failed before cycle %0d", cycleCount);
            $display("Errors found");
            $fatal(1);
        end else if (cycleCount > MaxCycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
            $display("Errors found");
            $fatal(1);
        end
    end

    function automatic int cellWeight(int idx);
        if (idx < dacPkg::NumBinaryCells) begin
            return 1 << idx;
        end
        return ThermW;
    endfunction

    function automatic logic cellBit(dacPkg::binCode_t bin, dacPkg::thermCode_t therm, int idx);
        if (idx < dacPkg::NumBinaryCells) begin
            return bin[idx];
        end
        return therm[idx - dacPkg::NumBinaryCells];
    endfunction

    // full code value, then remove diverted or lost cells from the rail they would feed
    function automatic expect_t wordExpect(dacPkg::binCode_t bin, dacPkg::thermCode_t therm,
                                           int calCell, int lostA, int lostB);
        expect_t e;
        int      pos;
        int      neg;
        int      cal;
        pos = int'(bin) + ThermW * $countones(therm);
        neg = FullScale - pos;
        cal = 0;
        for (int k = 0; k < dacPkg::NumCells; k++) begin
            if (k == calCell || k == lostA || k == lostB) begin
                if (cellBit(bin, therm, k)) begin
                    pos = pos - cellWeight(k);
                end else begin
                    neg = neg - cellWeight(k);
                end
                if (k == calCell && k != lostA && k != lostB) begin
                    cal = cellWeight(k);
                end
            end
        end
        e.check  = 1'b1;
        e.pos    = dacPkg::current_t'(pos);
        e.neg    = dacPkg::current_t'(neg);
        e.cal    = dacPkg::current_t'(cal);
        e.active = 1'b1;
        e.fault  = (lostA >= 0 || lostB >= 0);
        return e;
    endfunction

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // one clock per word, the word driven PipeDepth calls earlier is checked first
    task automatic driveWord(dacPkg::binCode_t bin, dacPkg::binCode_t binB,
                             dacPkg::thermCode_t therm, dacPkg::thermCode_t thermB,
                             dacPkg::calSel_t cal, logic pwr, expect_t exp);
        expect_t due;
        @(posedge clk);
        #1;
        if (expQ.size() == PipeDepth) begin
            due = expQ.pop_front();
            if (due.check) begin
                checkValue("iOut", due.pos, iOut);
                checkValue("iOutB", due.neg, iOutB);
                checkValue("iCal", due.cal, iCal);
                checkValue("outputActive", due.active, outputActive);
                checkValue("pairFault", due.fault, pairFault);
            end
        end
        dataIn     = bin;
        dataInB    = binB;
        dataTherm  = therm;
        dataThermB = thermB;
        calSelect  = cal;
        powerDownB = pwr;
        expQ.push_back(exp);
    endtask

    task automatic testReset();
        checkValue("iOut", 0, iOut);
        checkValue("iOutB", 0, iOutB);
        checkValue("iCal", 0, iCal);
        checkValue("outputActive", 0, outputActive);
        checkValue("pairFault", 0, pairFault);
    endtask

    task automatic testNormal();
        dacPkg::binCode_t   bin;
        dacPkg::thermCode_t therm;
        expect_t            e;
        repeat (50) begin
            bin   = $random(seed);
            therm = $random(seed);
            e     = '0;
            e.check  = 1'b1;
            e.pos    = dacPkg::current_t'(int'(bin) + ThermW * $countones(therm));
            e.neg    = dacPkg::current_t'(FullScale - int'(e.pos));
            e.active = 1'b1;
            driveWord(bin, ~bin, therm, ~therm, '0, 1'b1, e);
        end
    endtask

    task automatic testCalibration();
        dacPkg::binCode_t   bin;
        dacPkg::thermCode_t therm;
        for (int s = 1; s < 32; s++) begin
            bin   = $random(seed);
            therm = $random(seed);
            driveWord(bin, ~bin, therm, ~therm, dacPkg::calSel_t'(s), 1'b1,
                      wordExpect(bin, therm, (s <= dacPkg::NumCells) ? s - 1 : -1, -1, -1));
        end
    endtask

    task automatic testPairFault();
        dacPkg::binCode_t   bin;
        dacPkg::binCode_t   binB;
        dacPkg::thermCode_t therm;
        dacPkg::thermCode_t thermB;
        int                 thermIdx;
        for (int i = 0; i < dacPkg::NumBinaryCells; i++) begin
            bin      = $random(seed);
            therm    = $random(seed);
            thermIdx = (i * 4 + 1) % dacPkg::NumThermCells;
            binB     = ~bin;
            binB[i]  = bin[i];                            // true and complement agree
            thermB   = ~therm;
            thermB[thermIdx] = therm[thermIdx];
            driveWord(bin, binB, therm, thermB, '0, 1'b1,
                      wordExpect(bin, therm, -1, i, dacPkg::NumBinaryCells + thermIdx));
            bin   = $random(seed);
            therm = $random(seed);
            driveWord(bin, ~bin, therm, ~therm, '0, 1'b1, wordExpect(bin, therm, -1, -1, -1));
        end
    endtask

    task automatic testPowerDown();
        dacPkg::binCode_t   bin;
        dacPkg::thermCode_t therm;
        expect_t            off;
        off       = '0;
        off.check = 1'b1;
        repeat (6) begin
            bin   = $random(seed);
            therm = $random(seed);
            driveWord(bin, dacPkg::binCode_t'($random(seed)), therm,
                      dacPkg::thermCode_t'($random(seed)), dacPkg::calSel_t'($random(seed)),
                      1'b0, off);
        end
        repeat (4) begin
            bin   = $random(seed);
            therm = $random(seed);
            driveWord(bin, ~bin, therm, ~therm, '0, 1'b1, wordExpect(bin, therm, -1, -1, -1));
        end
    endtask

    initial begin
        reset      = 1'b1;
        dataIn     = '0;
        dataInB    = '1;
        dataTherm  = '0;
        dataThermB = '1;
        calSelect  = '0;
        powerDownB = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        testReset();
        testNormal();
        testCalibration();
        testPairFault();
        testPowerDown();
        repeat (PipeDepth) begin
            driveWord('0, '1, '0, '1, '0, 1'b1, '0);      // filler words flush the pipeline
        end
        @(posedge clk);                                   // assertions sample the last word here
        #1;
        if (uut.uCombiner.uProps.assertFails != 0) begin
            $display("%0d assertion failures during the run", uut.uCombiner.uProps.assertFails);
            $display("Errors found");
            $fatal(1);
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
rtl/dacPkg.sv
rtl/dacCodeDecoder.sv
rtl/steeringCell.sv
rtl/outputCombiner.sv
rtl/currentSteeringDac.sv
bench/dacTb_properties.sv
bench/dacTb.sv
